/* source/z8Pkg.sv */
package z8Pkg;

    typedef logic [7:0]  byteT;
    typedef logic [15:0] addrT;
    typedef logic [7:0]  regAddrT;
    typedef logic [3:0]  nibbleT;
    typedef logic [7:0]  flagsT;

    // Flag bit positions
    localparam int FlagC = 7;
    localparam int FlagZ = 6;
    localparam int FlagS = 5;
    localparam int FlagV = 4;

    // ALU1 codes are {0, opcode high nibble}, ALU2 codes are {1, high nibble}
    typedef enum logic [4:0] {
        AluDec  = 5'h00,
        AluRlc  = 5'h01,
        AluInc  = 5'h02,
        AluPass = 5'h03,
        AluCom  = 5'h06,
        AluRl   = 5'h09,
        AluClr  = 5'h0B,
        AluRrc  = 5'h0C,
        AluSra  = 5'h0D,
        AluRr   = 5'h0E,
        AluSwap = 5'h0F,
        AluAdd  = 5'h10,
        AluAdc  = 5'h11,
        AluSub  = 5'h12,
        AluSbc  = 5'h13,
        AluOr   = 5'h14,
        AluAnd  = 5'h15,
        AluTcm  = 5'h16,
        AluTm   = 5'h17,
        AluCp   = 5'h1A,
        AluXor  = 5'h1B
    } aluOpT;

    typedef enum logic [2:0] {
        KindLoad,
        KindAlu1,
        KindAlu2,
        KindJumpRel,
        KindJumpDirect,
        KindDjnz,
        KindSrp,
        KindFlagOp
    } opKindT;

    // Opcode low nibble classes
    localparam nibbleT NibAlu1    = 4'h0;
    localparam nibbleT NibSrp     = 4'h1;
    localparam nibbleT NibAlu2Reg = 4'h4;
    localparam nibbleT NibAlu2Imm = 4'h6;
    localparam nibbleT NibLdRReg  = 4'h8;
    localparam nibbleT NibDjnz    = 4'hA;
    localparam nibbleT NibJr      = 4'hB;
    localparam nibbleT NibLdRImm  = 4'hC;
    localparam nibbleT NibJp      = 4'hD;
    localparam nibbleT NibMisc    = 4'hF;

    // High nibbles with special meaning
    localparam nibbleT HiLoad = 4'hE;
    localparam nibbleT HiSrp  = 4'h3;
    localparam nibbleT HiCcf  = 4'hE;

    localparam addrT ResetPc = 16'h000C;

    localparam regAddrT RegFlags   = 8'hFC;
    localparam regAddrT RegPointer = 8'hFD;
    localparam regAddrT RegPort2   = 8'h02;

    localparam nibbleT WorkingPrefix = 4'hE;

endpackage

/* source/z8Ifs.sv */
interface instrIf;
    import z8Pkg::*;

    logic instrValid;
    byteT opcode;
    byteT second;
    byteT third;
    // Address of the byte after the instruction
    addrT pc;
    logic done;
    logic branchTaken;
    addrT branchPc;

    modport fetch (
        output instrValid, opcode, second, third, pc,
        input  done, branchTaken, branchPc
    );

    modport decode (
        input opcode, second, third
    );

    modport exec (
        input  instrValid, second, third, pc,
        output done, branchTaken, branchPc
    );
endinterface

interface execIf;
    import z8Pkg::*;

    logic    wrEn;
    regAddrT wrAddr;
    byteT    wrData;
    logic    flagsWrEn;
    flagsT   flagsData;
    logic    rpWrEn;
    nibbleT  rpData;
    regAddrT rdAddrA;
    regAddrT rdAddrB;
    byteT    rdDataA;
    byteT    rdDataB;
    flagsT   flags;
    nibbleT  rp;

    modport exec (
        output wrEn, wrAddr, wrData, flagsWrEn, flagsData, rpWrEn, rpData,
        output rdAddrA, rdAddrB,
        input  rdDataA, rdDataB, flags
    );

    modport regfile (
        input  wrEn, wrAddr, wrData, flagsWrEn, flagsData, rpWrEn, rpData,
        input  rdAddrA, rdAddrB,
        output rdDataA, rdDataB, flags, rp
    );
endinterface

/* source/instrFetch.sv */
module instrFetch (
    input  logic        clk,
    input  logic        arstN,
    output z8Pkg::addrT wbAdr,
    output logic        wbCyc,
    output logic        wbStb,
    input  z8Pkg::byteT wbDatIn,
    input  logic        wbAck,
    instrIf.fetch       fetch
);
    import z8Pkg::*;

    typedef enum logic [1:0] {
        Idle,
        BusByte,
        Hold
    } fetchStateT;

    fetchStateT state;
    addrT       pc;
    logic [1:0] byteCnt;
    logic [1:0] curLen;
    logic       lastByte;
    byteT       opcodeReg;
    byteT       secondReg;
    byteT       thirdReg;

    function automatic logic [1:0] instrLength(input nibbleT lowNib);
        case (lowNib)
            4'hE, 4'hF:                   return 2'd1;
            4'h4, 4'h5, 4'h6, 4'h7, 4'hD: return 2'd3;
            default:                      return 2'd2;
        endcase
    endfunction

    // Opcode is still on the bus while the first byte is acked
    assign curLen   = (byteCnt == 2'd0) ? instrLength(wbDatIn[3:0])
                                        : instrLength(opcodeReg[3:0]);
    assign lastByte = (byteCnt + 2'd1) == curLen;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state   <= Idle;
            pc      <= ResetPc;
            byteCnt <= 2'd0;
        end else begin
            case (state)
                Idle: begin
                    state <= BusByte;
                end
                BusByte: begin
                    if (wbAck) begin
                        pc <= pc + 16'd1;
                        if (lastByte) begin
                            byteCnt <= 2'd0;
                            state   <= Hold;
                        end else begin
                            byteCnt <= byteCnt + 2'd1;
                        end
                    end
                end
                Hold: begin
                    if (fetch.done) begin
                        state <= BusByte;
                        if (fetch.branchTaken) begin
                            pc <= fetch.branchPc;
                        end
                    end
                end
                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == BusByte && wbAck) begin
            case (byteCnt)
                2'd0:    opcodeReg <= wbDatIn;
                2'd1:    secondReg <= wbDatIn;
                default: thirdReg  <= wbDatIn;
            endcase
        end
    end

    assign wbAdr = pc;
    assign wbCyc = state == BusByte;
    assign wbStb = state == BusByte;

    assign fetch.instrValid = state == Hold;
    assign fetch.opcode     = opcodeReg;
    assign fetch.second     = secondReg;
    assign fetch.third      = thirdReg;
    assign fetch.pc         = pc;

endmodule

/* source/instrDecode.sv */
module instrDecode (
    instrIf.decode          instr,
    input  z8Pkg::nibbleT   rp,
    output z8Pkg::opKindT   kind,
    output z8Pkg::aluOpT    aluOp,
    output z8Pkg::regAddrT  dstAddr,
    output z8Pkg::regAddrT  srcAddr,
    output logic            useImm,
    output z8Pkg::byteT     immValue,
    output z8Pkg::nibbleT   cond,
    output logic            writesResult
);
    import z8Pkg::*;

    nibbleT hi;
    nibbleT lo;

    function automatic regAddrT r4(input nibbleT r);
        return {rp, r};
    endfunction

    // E-prefixed addresses point into the working bank
    function automatic regAddrT r8(input regAddrT r);
        return (r[7:4] == WorkingPrefix) ? r4(r[3:0]) : r;
    endfunction

    assign hi   = instr.opcode[7:4];
    assign lo   = instr.opcode[3:0];
    assign cond = hi;

    always_comb begin
        kind         = KindLoad;
        aluOp        = AluPass;
        dstAddr      = '0;
        srcAddr      = '0;
        useImm       = 1'b0;
        immValue     = instr.second;
        writesResult = 1'b0;

        case (lo)
            NibAlu1: begin
                // da, pop, push, decw, incw and jp @ are not kept
                if (!(hi inside {4'h3, 4'h4, 4'h5, 4'h7, 4'h8, 4'hA})) begin
                    kind         = KindAlu1;
                    aluOp        = aluOpT'({1'b0, hi});
                    dstAddr      = r8(instr.second);
                    srcAddr      = r8(instr.second);
                    writesResult = 1'b1;
                end
            end
            NibSrp: begin
                if (hi == HiSrp) begin
                    kind = KindSrp;
                end
            end
            NibAlu2Reg, NibAlu2Imm: begin
                if (lo == NibAlu2Imm) begin
                    dstAddr  = r8(instr.second);
                    immValue = instr.third;
                    useImm   = 1'b1;
                end else begin
                    dstAddr = r8(instr.third);
                    srcAddr = r8(instr.second);
                end
                if (hi == HiLoad) begin
                    writesResult = 1'b1;
                end else if (hi <= 4'h7 || hi == 4'hA || hi == 4'hB) begin
                    kind  = KindAlu2;
                    aluOp = aluOpT'({1'b1, hi});
                    // tcm, tm and cp only set flags
                    writesResult = !(hi inside {4'h6, 4'h7, 4'hA});
                end
            end
            NibLdRReg: begin
                dstAddr      = r4(hi);
                srcAddr      = r8(instr.second);
                writesResult = 1'b1;
            end
            NibDjnz: begin
                kind         = KindDjnz;
                aluOp        = AluDec;
                dstAddr      = r4(hi);
                srcAddr      = r4(hi);
                writesResult = 1'b1;
            end
            NibJr: kind = KindJumpRel;
            NibJp: kind = KindJumpDirect;
            NibLdRImm: begin
                dstAddr      = r4(hi);
                useImm       = 1'b1;
                writesResult = 1'b1;
            end
            NibMisc: begin
                if (hi inside {4'hC, 4'hD, 4'hE}) begin
                    kind = KindFlagOp;
                end
            end
            default: ;
        endcase
    end

endmodule

/* source/z8Alu.sv */
module z8Alu (
    input  z8Pkg::aluOpT op,
    input  z8Pkg::byteT  a,
    input  z8Pkg::byteT  b,
    input  z8Pkg::flagsT flagsIn,
    output z8Pkg::byteT  result,
    output z8Pkg::flagsT flagsOut
);
    import z8Pkg::*;

    logic       cin;
    logic [8:0] wide;
    logic       setZs;

    assign cin = flagsIn[FlagC];

    always_comb begin
        result   = b;
        flagsOut = flagsIn;
        wide     = '0;
        setZs    = 1'b1;

        case (op)
            AluAdd, AluAdc: begin
                wide            = {1'b0, a} + {1'b0, b} + {8'd0, op == AluAdc && cin};
                result          = wide[7:0];
                flagsOut[FlagC] = wide[8];
                flagsOut[FlagV] = (a[7] == b[7]) && (result[7] != a[7]);
            end
            AluSub, AluSbc, AluCp: begin
                // Borrow ends up in bit 8
                wide            = {1'b0, a} - {1'b0, b} - {8'd0, op == AluSbc && cin};
                result          = wide[7:0];
                flagsOut[FlagC] = wide[8];
                flagsOut[FlagV] = (a[7] != b[7]) && (result[7] != a[7]);
            end
            AluOr, AluAnd, AluTcm, AluTm, AluXor: begin
                case (op)
                    AluOr:   result = a | b;
                    AluAnd:  result = a & b;
                    AluTcm:  result = ~a & b;
                    AluTm:   result = a & b;
                    default: result = a ^ b;
                endcase
                flagsOut[FlagV] = 1'b0;
            end
            AluRlc, AluRl, AluRrc, AluRr, AluSra: begin
                case (op)
                    AluRlc:  result = {a[6:0], cin};
                    AluRl:   result = {a[6:0], a[7]};
                    AluRrc:  result = {cin, a[7:1]};
                    AluRr:   result = {a[0], a[7:1]};
                    default: result = {a[7], a[7:1]};
                endcase
                flagsOut[FlagC] = (op == AluRlc || op == AluRl) ? a[7] : a[0];
                flagsOut[FlagV] = result[7] ^ a[7];
            end
            AluInc: begin
                result          = a + 8'd1;
                flagsOut[FlagV] = a == 8'h7F;
            end
            AluDec: begin
                result          = a - 8'd1;
                flagsOut[FlagV] = a == 8'h80;
            end
            AluCom: begin
                result          = ~a;
                flagsOut[FlagV] = 1'b0;
            end
            AluSwap: result = {a[3:0], a[7:4]};
            AluClr: begin
                result = 8'h00;
                setZs  = 1'b0;
            end
            default: setZs = 1'b0;
        endcase

        if (setZs) begin
            flagsOut[FlagZ] = result == 8'h00;
            flagsOut[FlagS] = result[7];
        end
    end

endmodule

/* source/execUnit.sv */
module execUnit (
    instrIf.exec           instr,
    execIf.exec            regs,
    input z8Pkg::opKindT   kind,
    input z8Pkg::aluOpT    aluOp,
    input z8Pkg::regAddrT  dstAddr,
    input z8Pkg::regAddrT  srcAddr,
    input logic            useImm,
    input z8Pkg::byteT     immValue,
    input z8Pkg::nibbleT   cond,
    input logic            writesResult
);
    import z8Pkg::*;

    byteT  aluB;
    byteT  aluResult;
    flagsT aluFlags;
    logic  condMet;
    addrT  relTarget;

    // Upper eight codes invert the lower eight
    function automatic logic condTrue(input nibbleT cc, input flagsT f);
        logic base;
        case (cc[2:0])
            3'd0:    base = 1'b0;
            3'd1:    base = f[FlagS] ^ f[FlagV];
            3'd2:    base = (f[FlagS] ^ f[FlagV]) | f[FlagZ];
            3'd3:    base = f[FlagC] | f[FlagZ];
            3'd4:    base = f[FlagV];
            3'd5:    base = f[FlagS];
            3'd6:    base = f[FlagZ];
            default: base = f[FlagC];
        endcase
        return base ^ cc[3];
    endfunction

    assign regs.rdAddrA = dstAddr;
    assign regs.rdAddrB = srcAddr;
    assign aluB         = useImm ? immValue : regs.rdDataB;

    z8Alu uAlu (
        .op       (aluOp),
        .a        (regs.rdDataA),
        .b        (aluB),
        .flagsIn  (regs.flags),
        .result   (aluResult),
        .flagsOut (aluFlags)
    );

    assign condMet   = condTrue(cond, regs.flags);
    assign relTarget = instr.pc + {{8{instr.second[7]}}, instr.second};

    // Every kept instruction finishes in its first valid cycle
    assign instr.done        = instr.instrValid;
    assign instr.branchTaken = ((kind == KindJumpRel || kind == KindJumpDirect) && condMet)
                             || (kind == KindDjnz && aluResult != 8'h00);
    assign instr.branchPc    = (kind == KindJumpDirect) ? {instr.second, instr.third}
                                                        : relTarget;

    assign regs.wrEn   = instr.instrValid && writesResult;
    assign regs.wrAddr = dstAddr;
    assign regs.wrData = aluResult;

    assign regs.flagsWrEn = instr.instrValid
                          && (kind == KindAlu1 || kind == KindAlu2 || kind == KindFlagOp);

    always_comb begin
        regs.flagsData = aluFlags;
        if (kind == KindFlagOp) begin
            // ccf toggles, scf and rcf take bit 0 of the high nibble
            regs.flagsData[FlagC] = (cond == HiCcf) ? ~regs.flags[FlagC] : cond[0];
        end
    end

    assign regs.rpWrEn = instr.instrValid && kind == KindSrp;
    assign regs.rpData = immValue[7:4];

endmodule

/* source/regFile.sv */
module regFile (
    input  logic        clk,
    input  logic        arstN,
    execIf.regfile      regs,
    output z8Pkg::byteT port2
);
    import z8Pkg::*;

    byteT   mem [128];
    flagsT  flags;
    nibbleT rp;

    function automatic byteT readReg(input regAddrT addr);
        if (addr == RegPort2) begin
            return port2;
        end else if (!addr[7]) begin
            return mem[addr[6:0]];
        end else if (addr == RegFlags) begin
            return flags;
        end else if (addr == RegPointer) begin
            return {rp, 4'h0};
        end
        return 8'h00;
    endfunction

    always_ff @(posedge clk) begin
        if (regs.wrEn && !regs.wrAddr[7]) begin
            mem[regs.wrAddr[6:0]] <= regs.wrData;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            flags <= '0;
            rp    <= '0;
            port2 <= '0;
        end else begin
            // A direct write to FC wins over the ALU flags
            if (regs.wrEn && regs.wrAddr == RegFlags) begin
                flags <= regs.wrData;
            end else if (regs.flagsWrEn) begin
                flags <= regs.flagsData;
            end
            if (regs.rpWrEn) begin
                rp <= regs.rpData;
            end else if (regs.wrEn && regs.wrAddr == RegPointer) begin
                rp <= regs.wrData[7:4];
            end
            if (regs.wrEn && regs.wrAddr == RegPort2) begin
                port2 <= regs.wrData;
            end
        end
    end

    // Read ports follow register contents as well as the addresses
    always_comb begin
        regs.rdDataA = readReg(regs.rdAddrA);
        regs.rdDataB = readReg(regs.rdAddrB);
    end

    assign regs.flags = flags;
    assign regs.rp    = rp;

endmodule

/* source/z8Top.sv */
module z8Top (
    input  logic        clk,
    input  logic        arstN,
    output z8Pkg::addrT wbAdr,
    output logic        wbCyc,
    output logic        wbStb,
    input  z8Pkg::byteT wbDatIn,
    input  logic        wbAck,
    output z8Pkg::byteT port2
);
    import z8Pkg::*;

    opKindT  kind;
    aluOpT   aluOp;
    regAddrT dstAddr;
    regAddrT srcAddr;
    logic    useImm;
    byteT    immValue;
    nibbleT  cond;
    logic    writesResult;

    instrIf instrBus ();
    execIf  regsBus ();

    instrFetch uFetch (
        .clk     (clk),
        .arstN   (arstN),
        .wbAdr   (wbAdr),
        .wbCyc   (wbCyc),
        .wbStb   (wbStb),
        .wbDatIn (wbDatIn),
        .wbAck   (wbAck),
        .fetch   (instrBus.fetch)
    );

    instrDecode uDecode (
        .instr        (instrBus.decode),
        .rp           (regsBus.rp),
        .kind         (kind),
        .aluOp        (aluOp),
        .dstAddr      (dstAddr),
        .srcAddr      (srcAddr),
        .useImm       (useImm),
        .immValue     (immValue),
        .cond         (cond),
        .writesResult (writesResult)
    );

    execUnit uExec (
        .instr        (instrBus.exec),
        .regs         (regsBus.exec),
        .kind         (kind),
        .aluOp        (aluOp),
        .dstAddr      (dstAddr),
        .srcAddr      (srcAddr),
        .useImm       (useImm),
        .immValue     (immValue),
        .cond         (cond),
        .writesResult (writesResult)
    );

    regFile uRegs (
        .clk   (clk),
        .arstN (arstN),
        .regs  (regsBus.regfile),
        .port2 (port2)
    );

endmodule

/* sim/z8Program.svh */
`ifndef Z8_PROGRAM_SVH
`define Z8_PROGRAM_SVH

// Program image, first byte at ResetPc
byteT progRom [$] = {
    // Loads, srp bank switch, back to bank 0
    8'h2C, 8'h5A, 8'hE6, 8'h11, 8'h3C, 8'hE4, 8'h11, 8'h02,
    8'h31, 8'h10, 8'h6C, 8'hA7, 8'hE4, 8'h16, 8'h02,
    8'h28, 8'h11, 8'hE4, 8'hE2, 8'h02, 8'h31, 8'h00,
    // ALU2, reg 11 holds 3C, dst is reg 02
    8'h2C, 8'h50, 8'h04, 8'h11, 8'h02, 8'hE4, 8'hFC, 8'h02,
    8'h2C, 8'hF0, 8'h06, 8'h02, 8'h20, 8'hE4, 8'hFC, 8'h02,
    8'h2C, 8'h01, 8'h14, 8'h11, 8'h02, 8'hE4, 8'hFC, 8'h02,
    8'hDF, 8'h2C, 8'h7F, 8'h16, 8'h02, 8'h00, 8'hE4, 8'hFC, 8'h02,
    8'h2C, 8'h3C, 8'h24, 8'h11, 8'h02, 8'hE4, 8'hFC, 8'h02,
    8'h2C, 8'h10, 8'h26, 8'h02, 8'h20, 8'hE4, 8'hFC, 8'h02,
    8'h2C, 8'h80, 8'h34, 8'h11, 8'h02, 8'hE4, 8'hFC, 8'h02,
    8'h2C, 8'h05, 8'h36, 8'h02, 8'h05, 8'hE4, 8'hFC, 8'h02,
    8'h2C, 8'hC0, 8'h44, 8'h11, 8'h02, 8'hE4, 8'hFC, 8'h02,
    8'h2C, 8'h00, 8'h46, 8'h02, 8'h00, 8'hE4, 8'hFC, 8'h02,
    8'h2C, 8'h0F, 8'h54, 8'h11, 8'h02, 8'hE4, 8'hFC, 8'h02,
    8'h2C, 8'hF5, 8'h56, 8'h02, 8'hA0, 8'hE4, 8'hFC, 8'h02,
    8'h2C, 8'h3C, 8'h64, 8'h11, 8'h02, 8'hE4, 8'hFC, 8'h02,
    8'h2C, 8'h0F, 8'h66, 8'h02, 8'hF0, 8'hE4, 8'hFC, 8'h02,
    8'h2C, 8'h81, 8'h74, 8'h11, 8'h02, 8'hE4, 8'hFC, 8'h02,
    8'h2C, 8'h81, 8'h76, 8'h02, 8'h80, 8'hE4, 8'hFC, 8'h02,
    8'h2C, 8'h3C, 8'hA4, 8'h11, 8'h02, 8'hE4, 8'hFC, 8'h02,
    8'h2C, 8'h10, 8'hA6, 8'h02, 8'h20, 8'hE4, 8'hFC, 8'h02,
    8'h2C, 8'hFF, 8'hB4, 8'h11, 8'h02, 8'hE4, 8'hFC, 8'h02,
    8'h2C, 8'h5A, 8'hB6, 8'h02, 8'h5A, 8'hE4, 8'hFC, 8'h02,
    // ALU1 on reg 02: dec rlc inc com rl clr rrc sra rr swap
    8'h2C, 8'h01, 8'h00, 8'h02, 8'hE4, 8'hFC, 8'h02,
    8'h2C, 8'h80, 8'h10, 8'h02, 8'hE4, 8'hFC, 8'h02,
    8'h2C, 8'h7F, 8'h20, 8'h02, 8'hE4, 8'hFC, 8'h02,
    8'h2C, 8'h0F, 8'h60, 8'h02, 8'hE4, 8'hFC, 8'h02,
    8'h2C, 8'h40, 8'h90, 8'h02, 8'hE4, 8'hFC, 8'h02,
    8'h2C, 8'h55, 8'hB0, 8'h02, 8'hE4, 8'hFC, 8'h02,
    8'h2C, 8'h03, 8'hC0, 8'h02, 8'hE4, 8'hFC, 8'h02,
    8'h2C, 8'h81, 8'hD0, 8'h02, 8'hE4, 8'hFC, 8'h02,
    8'h2C, 8'h01, 8'hE0, 8'h02, 8'hE4, 8'hFC, 8'h02,
    8'h2C, 8'h70, 8'hF0, 8'h02, 8'hE4, 8'hFC, 8'h02,
    // rcf, scf, ccf
    8'hCF, 8'hE4, 8'hFC, 8'h02, 8'hDF, 8'hE4, 8'hFC, 8'h02, 8'hEF, 8'hE4, 8'hFC, 8'h02,
    // Branches at 0115, skipped loads write EE
    8'h8B, 8'h02, 8'h2C, 8'hEE, 8'h2C, 8'h11, 8'h6B, 8'h02, 8'h2C, 8'h22,
    8'h4D, 8'h01, 8'h24, 8'h2C, 8'hEE, 8'h2C, 8'h33, 8'h7D, 8'h01, 8'h2B, 8'h2C, 8'h44,
    // djnz loop over r3, counter copied to port2
    8'h3C, 8'h03, 8'hE4, 8'h03, 8'h02, 8'h3A, 8'hFB, 8'h2C, 8'hA5
};

// Every port2 write in order, flags byte is C Z S V in bits 7 to 4
byteT expPort2 [$] = {
    8'h5A, 8'h3C, 8'hA7, 8'h3C,
    8'h50, 8'h8C, 8'h30, 8'hF0, 8'h10, 8'h80, 8'h01, 8'h3E, 8'h00, 8'h7F, 8'h80, 8'h30,
    8'h3C, 8'h00, 8'h40, 8'h10, 8'hF0, 8'hA0, 8'h80, 8'h43, 8'h10, 8'h05, 8'h00, 8'h40,
    8'hC0, 8'hFC, 8'h20, 8'h00, 8'h00, 8'h40, 8'h0F, 8'h0C, 8'h00, 8'hF5, 8'hA0, 8'h20,
    8'h3C, 8'h40, 8'h0F, 8'h20, 8'h81, 8'h40, 8'h81, 8'h20, 8'h3C, 8'h40, 8'h10, 8'hA0,
    8'hFF, 8'hC3, 8'hA0, 8'h5A, 8'h00, 8'hC0,
    8'h01, 8'h00, 8'hC0, 8'h80, 8'h01, 8'h90, 8'h7F, 8'h80, 8'hB0, 8'h0F, 8'hF0, 8'hA0,
    8'h40, 8'h80, 8'h30, 8'h55, 8'h00, 8'h30, 8'h03, 8'h01, 8'h80, 8'h81, 8'hC0, 8'hA0,
    8'h01, 8'h80, 8'hB0, 8'h70, 8'h07, 8'h90,
    8'h10, 8'h90, 8'h10,
    8'h11, 8'h22, 8'h33, 8'h44, 8'h03, 8'h02, 8'h01, 8'hA5
};

// Fetch address after each jr, jp and djnz
addrT expTargets [$] = {
    16'h0119, 16'h011D, 16'h0124, 16'h0129, 16'h012D, 16'h012D, 16'h0132
};

localparam int LoadEnd  = 4;
localparam int Alu2End  = 58;
localparam int Alu1End  = 88;
localparam int CarryEnd = 91;

`endif

/* sim/z8Tb.sv */
module z8Tb;
    import z8Pkg::*;

    `include "z8Program.svh"

    localparam int ClkPeriod = 8;

    logic   clk;
    logic   arstN;
    addrT   wbAdr;
    logic   wbCyc;
    logic   wbStb;
    byteT   wbDatIn;
    logic   wbAck;
    byteT   port2;

    integer seed;
    int     waitLeft;
    logic   busy;
    logic   prevStb;
    logic   prevAck;
    addrT   prevAdr;
    logic   firstSeen;
    logic   wrPending;
    logic   branchPending;
    int     expIdx;
    int     targetIdx;
    int     cycles;
    int     cycleLimit;

    z8Top i_dut (
        .clk     (clk),
        .arstN   (arstN),
        .wbAdr   (wbAdr),
        .wbCyc   (wbCyc),
        .wbStb   (wbStb),
        .wbDatIn (wbDatIn),
        .wbAck   (wbAck),
        .port2   (port2)
    );

    task automatic failValue(input string testName, input int expected, input int actual);
        $display("[ERROR] %s: expected %0h, actual %0h", testName, expected, actual);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic failText(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    function automatic string sectionName(input int idx);
        if (idx < LoadEnd) begin
            return "loads and srp";
        end else if (idx < Alu2End) begin
            return "alu2";
        end else if (idx < Alu1End) begin
            return "alu1";
        end else if (idx < CarryEnd) begin
            return "carry controls";
        end
        return "branches";
    endfunction

    // Addresses outside the image read as nop
    function automatic byteT readByte(input addrT adr);
        int offset;
        offset = int'(adr) - int'(ResetPc);
        if (offset >= 0 && offset < progRom.size()) begin
            return progRom[offset];
        end
        return 8'hFF;
    endfunction

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        seed          = 32'h4d49_1a5e;
        arstN         = 1'b0;
        wbAck         = 1'b0;
        wbDatIn       = 8'h00;
        busy          = 1'b0;
        waitLeft      = 0;
        prevStb       = 1'b0;
        prevAck       = 1'b0;
        prevAdr       = '0;
        firstSeen     = 1'b0;
        wrPending     = 1'b0;
        branchPending = 1'b0;
        expIdx        = 0;
        targetIdx     = 0;
        cycles        = 0;
        cycleLimit    = 40 * progRom.size() + 200;
        repeat (16) begin
            @(negedge clk);
            assert (!wbCyc && !wbStb) else failText("bus cycle started during reset");
        end
        arstN = 1'b1;
        #(ClkPeriod / 4);
        assert (!wbCyc && !wbStb) else failText("bus cycle started in first cycle after reset");
    end

    always @(negedge clk) begin
        if (arstN) begin
            cycles = cycles + 1;
            if (cycles >= cycleLimit) begin
                $display("*** TEST FAILED ***");
                $fatal(1, "timeout, program did not finish");
            end
        end
    end

    always @(negedge clk) begin
        if (arstN) begin
            if (prevStb && !prevAck) begin
                assert (wbStb && wbCyc && wbAdr == prevAdr)
                    else failText("wbStb fell or wbAdr moved before the ack");
            end
            if (wbStb && !firstSeen) begin
                firstSeen = 1'b1;
                assert (wbAdr == ResetPc) else failValue("reset address", ResetPc, wbAdr);
            end

            // Next fetch address right after a branch completes
            if (branchPending) begin
                branchPending = 1'b0;
                assert (targetIdx < expTargets.size()) else failText("more branches than expected");
                assert (wbStb && wbAdr == expTargets[targetIdx])
                    else failValue("branch target", expTargets[targetIdx], wbAdr);
                targetIdx = targetIdx + 1;
            end
            if (i_dut.instrBus.done
                && (i_dut.instrBus.opcode[3:0] inside {NibDjnz, NibJr, NibJp})) begin
                branchPending = 1'b1;
            end

            // Memory model with 0 to 3 wait cycles
            prevStb = wbStb;
            prevAdr = wbAdr;
            wbAck   = 1'b0;
            if (wbStb) begin
                if (!busy) begin
                    busy     = 1'b1;
                    waitLeft = $unsigned($random(seed)) % 4;
                end
                if (waitLeft == 0) begin
                    wbAck   = 1'b1;
                    wbDatIn = readByte(wbAdr);
                    busy    = 1'b0;
                end else begin
                    waitLeft = waitLeft - 1;
                end
            end
            prevAck = wbAck;

            // port2 has settled one cycle after the write
            if (wrPending) begin
                assert (port2 == expPort2[expIdx])
                    else failValue(sectionName(expIdx), expPort2[expIdx], port2);
                expIdx = expIdx + 1;
            end
            wrPending = i_dut.regsBus.wrEn && i_dut.regsBus.wrAddr == RegPort2;
            if (expIdx == expPort2.size()) begin
                $display("*** TEST PASSED ***");
                $finish;
            end
        end
    end

endmodule

/* vlog.f */
+incdir+sim
source/z8Pkg.sv
source/z8Ifs.sv
source/instrFetch.sv
source/instrDecode.sv
source/z8Alu.sv
source/execUnit.sv
source/regFile.sv
source/z8Top.sv
sim/z8Tb.sv

/* Bender.yml */
package:
  name: z8

sources:
  - source/z8Pkg.sv
  - source/z8Ifs.sv
  - source/instrFetch.sv
  - source/instrDecode.sv
  - source/z8Alu.sv
  - source/execUnit.sv
  - source/regFile.sv
  - source/z8Top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/z8Tb.sv
